// File: Makefile
# Verilator build and run of the shared memory port testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := mem_share_tb
RTL_TOP   := mem_share_top
FILELIST  := build.f
OBJDIR    := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: build.f
+incdir+hdl
hdl/mem_share_pkg.sv
hdl/rr_arb_tree.sv
hdl/mem_bank.sv
hdl/rsp_router.sv
hdl/mem_share_top.sv
verification/mem_share_tb.sv

// File: hdl/mem_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_share_settings.svh"

module mem_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  mem_share_pkg::mem_op_e op_i,
  input  mem_share_pkg::addr_t   addr_i,
  input  mem_share_pkg::data_t   wdata_i,
  output logic                   ready_o,
  output logic                   accept_o,
  output logic                   rd_valid_o,
  output mem_share_pkg::data_t   rdata_o
);

  import mem_share_pkg::*;

  // one word per address
  localparam int unsigned Depth = 2 ** `MEM_SHARE_ADDR_W;

  data_t mem_q [Depth];

  // high for the cycle right after a write
  logic  recover_q;

  // read return
  logic  rd_valid_q;
  data_t rdata_q;

  // decoded acceptance
  logic  wr_en;
  logic  rd_en;

  ////////////////////////////////////////////////////////////
  // acceptance and recovery
  ////////////////////////////////////////////////////////////

  // refuse service during the recovery cycle
  assign ready_o  = ~recover_q;
  assign accept_o = req_i & ready_o;

  assign wr_en = accept_o & (op_i == OP_WRITE);
  assign rd_en = accept_o & (op_i == OP_READ);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      recover_q  <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      // a write always costs exactly one idle cycle
      recover_q  <= wr_en;
      rd_valid_q <= rd_en;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (wr_en) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read word lands one edge after acceptance
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rdata_o    = rdata_q;

endmodule : mem_bank

`default_nettype wire

// File: hdl/mem_share_pkg.sv
`default_nettype none

`include "mem_share_settings.svh"

package mem_share_pkg;

  // opcode carried with every request
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // index of a requester, also the arbiter winner index
  typedef logic [$clog2(`MEM_SHARE_NUM_REQ)-1:0] req_idx_t;

  // word address into the bank
  typedef logic [`MEM_SHARE_ADDR_W-1:0] addr_t;

  // one data word
  typedef logic [`MEM_SHARE_DATA_W-1:0] data_t;

endpackage : mem_share_pkg

`default_nettype wire

// File: hdl/mem_share_settings.svh
`ifndef MEM_SHARE_SETTINGS_SVH
`define MEM_SHARE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// shared memory port sizing
////////////////////////////////////////////////////////////

// number of requesters sharing the bank
`define MEM_SHARE_NUM_REQ 4

// word address width, 64 words in the bank
`define MEM_SHARE_ADDR_W 6

// width of one data word
`define MEM_SHARE_DATA_W 32

`endif

// File: hdl/mem_share_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_share_settings.svh"

module mem_share_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // requesters
  input  logic [`MEM_SHARE_NUM_REQ-1:0] req_i,
  input  mem_share_pkg::mem_op_e        op_i    [`MEM_SHARE_NUM_REQ],
  input  mem_share_pkg::addr_t          addr_i  [`MEM_SHARE_NUM_REQ],
  input  mem_share_pkg::data_t          wdata_i [`MEM_SHARE_NUM_REQ],
  output logic [`MEM_SHARE_NUM_REQ-1:0] gnt_o,
  // responses
  output logic [`MEM_SHARE_NUM_REQ-1:0] rsp_valid_o,
  output mem_share_pkg::data_t          rdata_o
);

  import mem_share_pkg::*;

  // payload is opcode, address and data
  localparam int unsigned PayloadW = 1 + `MEM_SHARE_ADDR_W + `MEM_SHARE_DATA_W;

  logic [`MEM_SHARE_NUM_REQ-1:0][PayloadW-1:0] payload;

  // arbitrated request toward the bank
  logic                arb_req;
  logic [PayloadW-1:0] arb_data;
  req_idx_t            arb_idx;

  // unpacked bank fields
  logic                arb_op_bit;
  mem_op_e             bank_op;
  addr_t               bank_addr;
  data_t               bank_wdata;

  // bank status
  logic                bank_ready;
  logic                bank_accept;
  logic                bank_rd_valid;

  // opcode sits on top so the data word stays aligned at bit 0
  for (genvar i = 0; i < `MEM_SHARE_NUM_REQ; i++) begin : gen_pack
    assign payload[i] = {op_i[i], addr_i[i], wdata_i[i]};
  end

  rr_arb_tree #(
    .NumIn     (`MEM_SHARE_NUM_REQ),
    .DataWidth (PayloadW)
  ) rr_arb_tree_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (req_i),
    .gnt_o   (gnt_o),
    .data_i  (payload),
    .gnt_i   (bank_ready),
    .req_o   (arb_req),
    .data_o  (arb_data),
    .idx_o   (arb_idx)
  );

  assign {arb_op_bit, bank_addr, bank_wdata} = arb_data;
  assign bank_op = mem_op_e'(arb_op_bit);

  mem_bank mem_bank_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (arb_req),
    .op_i       (bank_op),
    .addr_i     (bank_addr),
    .wdata_i    (bank_wdata),
    .ready_o    (bank_ready),
    .accept_o   (bank_accept),
    .rd_valid_o (bank_rd_valid),
    .rdata_o    (rdata_o)
  );

  // router reuses the bank's strobe and opcode
  rsp_router rsp_router_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (bank_accept),
    .op_i        (bank_op),
    .idx_i       (arb_idx),
    .rd_valid_i  (bank_rd_valid),
    .rsp_valid_o (rsp_valid_o)
  );

endmodule : mem_share_top

`default_nettype wire

// File: hdl/rr_arb_tree.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arb_tree #(
  parameter int unsigned NumIn     = 4,
  parameter int unsigned DataWidth = 32
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  // requester side
  input  logic [NumIn-1:0]                req_i,
  output logic [NumIn-1:0]                gnt_o,
  input  logic [NumIn-1:0][DataWidth-1:0] data_i,
  // shared resource side
  input  logic                            gnt_i,
  output logic                            req_o,
  output logic [DataWidth-1:0]            data_o,
  output logic [$clog2(NumIn)-1:0]        idx_o
);

  // number of selector levels and nodes in a full binary tree
  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumNodes  = 2 ** NumLevels - 1;

  // per node request, winner index, payload and grant
  logic [NumNodes-1:0]                 req_nodes;
  logic [NumNodes-1:0][NumLevels-1:0]  index_nodes;
  logic [NumNodes-1:0][DataWidth-1:0]  data_nodes;
  logic [NumNodes-1:0]                 gnt_nodes;

  // round robin counter
  logic [NumLevels-1:0] rr_d, rr_q;

  // lock state, frozen request vector while the output is refused
  logic                 lock_d, lock_q;
  logic [NumIn-1:0]     req_d, req_q;

  // request accepted by the shared resource this cycle
  logic                 accept;

  ////////////////////////////////////////////////////////////
  // root of the tree drives the shared side
  ////////////////////////////////////////////////////////////

  assign req_o        = req_nodes[0];
  assign data_o       = data_nodes[0];
  assign idx_o        = index_nodes[0];
  assign gnt_nodes[0] = gnt_i;

  assign accept = req_o & gnt_i;

  ////////////////////////////////////////////////////////////
  // lock-in and round robin state
  ////////////////////////////////////////////////////////////

  // pending but refused, keep the same decision next cycle
  assign lock_d = req_o & ~gnt_i;

  // while locked the tree sees last cycle's request vector
  assign req_d = lock_q ? req_q : req_i;

  // counter moves on each acceptance, wraps at NumIn
  always_comb begin
    rr_d = rr_q;
    if (accept) begin
      if (rr_q == NumLevels'(NumIn - 1)) begin
        rr_d = '0;
      end else begin
        rr_d = rr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else if (flush_i) begin
      // flush drops the lock and restarts rotation
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= lock_d;
      req_q  <= req_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // selector tree, level 0 is the root
  ////////////////////////////////////////////////////////////

  for (genvar level = 0; level < int'(NumLevels); level++) begin : gen_level
    for (genvar node = 0; node < 2 ** level; node++) begin : gen_node
      // this node and its lower child in the flat node arrays
      localparam int unsigned Cur   = 2 ** level - 1 + node;
      localparam int unsigned Child = 2 ** (level + 1) - 1 + node * 2;
      // counter bit that breaks ties on this level
      localparam int unsigned RrBit = NumLevels - 1 - level;

      if (level == int'(NumLevels) - 1) begin : gen_leaf
        // leaves take the inputs directly, pairing 2k and 2k+1
        if (node * 2 < int'(NumIn) - 1) begin : gen_pair
          logic sel;

          assign req_nodes[Cur] = req_d[node*2] | req_d[node*2+1];

          // upper input wins if lower is idle, or on a tie with the bit set
          assign sel = ~req_d[node*2] | (req_d[node*2+1] & rr_q[RrBit]);

          assign index_nodes[Cur] = NumLevels'(sel);
          assign data_nodes[Cur]  = sel ? data_i[node*2+1] : data_i[node*2];

          // grant only a requesting input on the selected side
          assign gnt_o[node*2]   = gnt_nodes[Cur] & req_d[node*2] & ~sel;
          assign gnt_o[node*2+1] = gnt_nodes[Cur] & req_d[node*2+1] & sel;
        end else if (node * 2 == int'(NumIn) - 1) begin : gen_single
          // odd last input, nothing to pick against
          assign req_nodes[Cur]   = req_d[node*2];
          assign index_nodes[Cur] = '0;
          assign data_nodes[Cur]  = data_i[node*2];
          assign gnt_o[node*2]    = gnt_nodes[Cur] & req_d[node*2];
        end else begin : gen_empty
          // leaf past the last input never requests
          assign req_nodes[Cur]   = 1'b0;
          assign index_nodes[Cur] = '0;
          assign data_nodes[Cur]  = '0;
        end
      end else begin : gen_inner
        logic sel;

        assign req_nodes[Cur] = req_nodes[Child] | req_nodes[Child+1];

        // same rule as the leaves, applied to the two subtrees
        assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & rr_q[RrBit]);

        // this level's select becomes the next index bit up
        assign index_nodes[Cur] = sel ?
          NumLevels'({1'b1, index_nodes[Child+1][RrBit-1:0]}) :
          NumLevels'({1'b0, index_nodes[Child][RrBit-1:0]});

        assign data_nodes[Cur] = sel ? data_nodes[Child+1] : data_nodes[Child];

        // grant follows the selection down
        assign gnt_nodes[Child]   = gnt_nodes[Cur] & ~sel;
        assign gnt_nodes[Child+1] = gnt_nodes[Cur] & sel;
      end
    end
  end

endmodule : rr_arb_tree

`default_nettype wire

// File: hdl/rsp_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_share_settings.svh"

module rsp_router (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // acceptance seen at the bank
  input  logic                          accept_i,
  input  mem_share_pkg::mem_op_e        op_i,
  input  mem_share_pkg::req_idx_t       idx_i,
  // read return from the bank
  input  logic                          rd_valid_i,
  output logic [`MEM_SHARE_NUM_REQ-1:0] rsp_valid_o
);

  import mem_share_pkg::*;

  // winner of the last accepted read
  req_idx_t idx_q;

  // capture strobe for the index
  logic     rd_accept;

  ////////////////////////////////////////////////////////////
  // remember who asked
  ////////////////////////////////////////////////////////////

  assign rd_accept = accept_i & (op_i == OP_READ);

  // bank latency is fixed, so one slot is enough
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (rd_accept) begin
      idx_q <= idx_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // one-hot response
  ////////////////////////////////////////////////////////////

  // pulse only the requester that issued the read
  always_comb begin
    rsp_valid_o = '0;
    for (int i = 0; i < `MEM_SHARE_NUM_REQ; i++) begin
      if (rd_valid_i && (idx_q == req_idx_t'(i))) begin
        rsp_valid_o[i] = 1'b1;
      end
    end
  end

endmodule : rsp_router

`default_nettype wire

// File: verification/mem_share_stimulus.txt
# columns: requester op(0 read, 1 write) address(hex) write data(hex) expected read data(hex)
# each requester owns 16 words (requester r uses addresses r*16 to r*16+15)
0 1 00 a5a50000 00000000
0 1 01 a5a50001 00000000
0 0 00 00000000 a5a50000
0 1 02 12345678 00000000
0 0 05 00000000 00000000
0 1 00 deadbeef 00000000
0 0 00 00000000 deadbeef
0 0 02 00000000 12345678
1 1 10 5a5a0010 00000000
1 1 11 5a5a0011 00000000
1 0 11 00000000 5a5a0011
1 0 10 00000000 5a5a0010
1 1 1f ffffffff 00000000
1 0 1e 00000000 00000000
1 0 1f 00000000 ffffffff
1 0 11 00000000 5a5a0011
2 0 20 00000000 00000000
2 1 20 0badf00d 00000000
2 1 21 00000001 00000000
2 1 22 80000000 00000000
2 0 22 00000000 80000000
2 0 20 00000000 0badf00d
2 0 21 00000000 00000001
2 1 21 c0ffee00 00000000
2 0 21 00000000 c0ffee00
3 1 30 11111111 00000000
3 1 31 22222222 00000000
3 1 32 33333333 00000000
3 0 31 00000000 22222222
3 0 30 00000000 11111111
3 0 32 00000000 33333333
3 1 3f 76543210 00000000
3 0 3f 00000000 76543210

// File: verification/mem_share_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_share_settings.svh"

module mem_share_tb;

  import mem_share_pkg::*;

  localparam int NumReq      = `MEM_SHARE_NUM_REQ;
  localparam int MaxTxn      = 128;
  localparam int ResetCycles = 10;

  // dut connections
  logic              clk;
  logic              rst_n;
  logic              flush;
  logic [NumReq-1:0] req;
  mem_op_e           op    [NumReq];
  addr_t             addr  [NumReq];
  data_t             wdata [NumReq];
  logic [NumReq-1:0] gnt;
  logic [NumReq-1:0] rsp_valid;
  data_t             rdata;

  // transactions from the stimulus file
  int       txn_count;
  req_idx_t txn_req   [MaxTxn];
  mem_op_e  txn_op    [MaxTxn];
  addr_t    txn_addr  [MaxTxn];
  data_t    txn_wdata [MaxTxn];
  data_t    txn_exp   [MaxTxn];

  // transaction held on each requester port or -1 when idle
  int cur_txn   [NumReq];
  int issue_ptr [NumReq];

  // model of the arbiter and the bank
  logic [1:0]        m_rr;
  logic              m_lock;
  logic [NumReq-1:0] m_lock_vec;
  logic              m_recover;
  data_t             mirror [2 ** `MEM_SHARE_ADDR_W];

  // read response due next cycle
  logic     exp_rsp;
  req_idx_t exp_rsp_idx;
  int       exp_rsp_txn;
  data_t    exp_rsp_data;

  // winner frozen by a refusal
  logic     pend_valid;
  req_idx_t pend_idx;

  logic [31:0] rng_state;
  logic        flush_done;
  int          done_count;
  int          errors;
  int          limit_cycles = 0;

  mem_share_top mem_share_top_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .flush_i     (flush),
    .req_i       (req),
    .op_i        (op),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .gnt_o       (gnt),
    .rsp_valid_o (rsp_valid),
    .rdata_o     (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [NumReq-1:0] onehot(input req_idx_t idx);
    logic [NumReq-1:0] v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // leaves pair 0/1 and 2/3 on rr bit 0 and the root picks a pair on rr bit 1
  function automatic req_idx_t pick_winner(input logic [NumReq-1:0] r, input logic [1:0] rr);
    logic lo_sel;
    logic hi_sel;
    logic root_sel;
    lo_sel   = ~r[0] | (r[1] & rr[0]);
    hi_sel   = ~r[2] | (r[3] & rr[0]);
    root_sel = ~(r[0] | r[1]) | ((r[2] | r[3]) & rr[1]);
    if (root_sel) begin
      return {1'b1, hi_sel};
    end else begin
      return {1'b0, lo_sel};
    end
  endfunction

  function automatic int find_next(input int r, input int start);
    for (int i = start; i < txn_count; i++) begin
      if (int'(txn_req[i]) == r) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic log_mismatch(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
    $display("[ERROR] time %0t %s expected 0x%08h actual 0x%08h", $time, name, expv, actv);
    errors++;
  endtask

  task automatic note_fault(input string msg);
    $display("error at time %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_req;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_exp;
    txn_count = 0;
    fd = $fopen("verification/mem_share_stimulus.txt", "r");
    if (fd == 0) begin
      note_fault("stimulus file verification/mem_share_stimulus.txt could not be opened");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // skip comment and blank lines
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%d %d %h %h %h", f_req, f_op, f_addr, f_wdata, f_exp);
          if (n != 5 || f_req >= NumReq || txn_count >= MaxTxn) begin
            note_fault($sformatf("stimulus line not usable: %s", line));
          end else begin
            txn_req[txn_count]   = req_idx_t'(f_req);
            txn_op[txn_count]    = f_op[0] ? OP_WRITE : OP_READ;
            txn_addr[txn_count]  = addr_t'(f_addr);
            txn_wdata[txn_count] = f_wdata;
            txn_exp[txn_count]   = f_exp;
            txn_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic drive_requests();
    int t;
    for (int r = 0; r < NumReq; r++) begin
      rng_state = xorshift32(rng_state);
      if (cur_txn[r] < 0) begin
        t = find_next(r, issue_ptr[r]);
        // idle requester joins after a random delay
        if (t >= 0 && rng_state[1:0] != 2'b00) begin
          cur_txn[r]   = t;
          issue_ptr[r] = t + 1;
        end
      end
      if (cur_txn[r] >= 0) begin
        // held stable until granted
        t        = cur_txn[r];
        req[r]   = 1'b1;
        op[r]    = txn_op[t];
        addr[r]  = txn_addr[t];
        wdata[r] = txn_wdata[t];
      end else begin
        // idle payload is junk that must never reach the bank
        req[r]   = 1'b0;
        op[r]    = OP_READ;
        addr[r]  = addr_t'(rng_state);
        wdata[r] = rng_state;
      end
    end
    // single flush pulse once half of the traffic is through
    if (!flush_done && done_count >= txn_count / 2) begin
      flush      = 1'b1;
      flush_done = 1'b1;
    end else begin
      flush = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one clock cycle of drive, check and model update
  ////////////////////////////////////////////////////////////

  task automatic run_cycle();
    logic [NumReq-1:0] eff_req;
    logic [NumReq-1:0] exp_gnt;
    logic [NumReq-1:0] exp_rsp_vec;
    logic              any_req;
    logic              ready;
    logic              accept;
    logic              next_rsp;
    req_idx_t          win;
    int                t;

    @(negedge clk);
    drive_requests();
    #1;

    // while locked the decision uses the vector from the refused cycle
    eff_req = m_lock ? m_lock_vec : req;
    any_req = |eff_req;
    ready   = ~m_recover;
    win     = pick_winner(eff_req, m_rr);
    accept  = any_req & ready;
    exp_gnt = accept ? onehot(win) : '0;

    if ($countones(gnt) > 1) begin
      note_fault($sformatf("gnt_o 0b%b has more than one bit set", gnt));
    end
    if (gnt !== exp_gnt) begin
      log_mismatch("gnt_o", 32'(exp_gnt), 32'(gnt));
    end
    // bank is in its recovery cycle
    if (m_recover && gnt !== '0) begin
      note_fault("grant given during the write recovery cycle");
    end
    // grant after a refusal goes to the locked winner
    if (pend_valid && gnt !== '0 && gnt !== onehot(pend_idx)) begin
      log_mismatch("gnt_o after lock", 32'(onehot(pend_idx)), 32'(gnt));
    end

    // response for a read accepted one cycle ago
    exp_rsp_vec = exp_rsp ? onehot(exp_rsp_idx) : '0;
    if (rsp_valid !== exp_rsp_vec) begin
      log_mismatch("rsp_valid_o", 32'(exp_rsp_vec), 32'(rsp_valid));
    end
    if (exp_rsp) begin
      if (rdata !== txn_exp[exp_rsp_txn]) begin
        log_mismatch("rdata_o", txn_exp[exp_rsp_txn], rdata);
      end
      if (rdata !== exp_rsp_data) begin
        log_mismatch("rdata_o vs mirror", exp_rsp_data, rdata);
      end
    end

    if (any_req && !ready && !pend_valid) begin
      pend_valid = 1'b1;
      pend_idx   = win;
    end
    if (accept) begin
      pend_valid = 1'b0;
    end

    // requesters and bank model follow the grants the DUT gave
    next_rsp  = 1'b0;
    m_recover = 1'b0;
    for (int r = 0; r < NumReq; r++) begin
      if (gnt[r] === 1'b1) begin
        t = cur_txn[r];
        if (t < 0) begin
          note_fault($sformatf("grant given to idle requester %0d", r));
        end else begin
          if (txn_op[t] == OP_WRITE) begin
            mirror[txn_addr[t]] = txn_wdata[t];
            m_recover           = 1'b1;
          end else begin
            next_rsp     = 1'b1;
            exp_rsp_idx  = req_idx_t'(r);
            exp_rsp_txn  = t;
            exp_rsp_data = mirror[txn_addr[t]];
          end
          cur_txn[r] = -1;
          done_count++;
        end
      end
    end
    exp_rsp = next_rsp;

    // flush restarts rotation from counter 0 and keeps memory
    if (flush) begin
      m_rr       = 2'd0;
      m_lock     = 1'b0;
      m_lock_vec = '0;
      pend_valid = 1'b0;
    end else begin
      if (accept) begin
        m_rr = m_rr + 2'd1;
      end
      m_lock     = any_req & ~ready;
      m_lock_vec = eff_req;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    req   = '0;
    for (int r = 0; r < NumReq; r++) begin
      op[r]        = OP_READ;
      addr[r]      = '0;
      wdata[r]     = '0;
      cur_txn[r]   = -1;
      issue_ptr[r] = 0;
    end
    foreach (mirror[i]) begin
      mirror[i] = '0;
    end
    m_rr        = 2'd0;
    m_lock      = 1'b0;
    m_lock_vec  = '0;
    m_recover   = 1'b0;
    exp_rsp     = 1'b0;
    exp_rsp_idx = '0;
    exp_rsp_txn = 0;
    pend_valid  = 1'b0;
    pend_idx    = '0;
    rng_state   = 32'h5930272d;
    flush_done  = 1'b0;
    done_count  = 0;
    errors      = 0;

    load_stimulus();
    limit_cycles = txn_count * 8 + 200;

    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset
    repeat (2) begin
      @(negedge clk);
      #1;
      if (gnt !== '0) begin
        log_mismatch("gnt_o after reset", 32'd0, 32'(gnt));
      end
      if (rsp_valid !== '0) begin
        log_mismatch("rsp_valid_o after reset", 32'd0, 32'(rsp_valid));
      end
    end

    while (done_count < txn_count || exp_rsp) begin
      run_cycle();
    end
    // idle tail catches stray grants or responses
    repeat (2) run_cycle();

    $display("transactions %0d of %0d, errors %0d", done_count, txn_count, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog sized from the transaction count
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : mem_share_tb

`default_nettype wire
